// File: rtl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int BIT_CLKS       = 16;
  localparam int HALF_BIT_CLKS  = BIT_CLKS / 2;
  localparam int GAP_CLKS       = 100;        // Idle cycles between write frames.
  localparam int CMD_WIDTH      = 16;
  localparam int BYTE_WIDTH     = 8;
  localparam int WRITE_FLAG_BIT = 15;

  localparam int BIT_CNT_W = $clog2(BIT_CLKS);
  localparam int GAP_CNT_W = $clog2(GAP_CLKS);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_HIGH,
    SEQ_GAP,
    SEQ_SEND_LOW,
    SEQ_WAIT_READ
  } seq_state_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

// File: rtl/uart_tx_byte_if.sv
`timescale 1ns/1ps

interface uart_tx_byte_if
  import uart_cmd_pkg::*;
();

  logic                  start; // One-cycle request, only while busy is low.
  logic [BYTE_WIDTH-1:0] data;
  logic                  busy;
  logic                  done;  // Last cycle of the stop bit.

  modport seq (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport ser (
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

// File: rtl/uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer
  import uart_cmd_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  uart_tx_byte_if.ser  byte_if,
  output logic         tx
);

  tx_state_t             state;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [2:0]            bit_idx;
  logic [BYTE_WIDTH-1:0] data_q;
  logic                  parity;
  logic                  bit_end;

  assign bit_end = (bit_cnt == BIT_CNT_W'(BIT_CLKS - 1));
  assign parity  = ~^data_q; // Odd parity over data plus parity bit.

  // Byte is captured on the start cycle.
  always_ff @(posedge clk)
  begin
    if (state == TX_IDLE && byte_if.start)
      data_q <= byte_if.data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (state == TX_IDLE)
    begin
      bit_cnt <= '0;
      bit_idx <= '0;
      if (byte_if.start)
        state <= TX_START;
    end
    else if (!bit_end)
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
    begin
      bit_cnt <= '0;
      case (state)
        TX_START:  state <= TX_DATA;
        TX_DATA:
        begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7)
            state <= TX_PARITY;
        end
        TX_PARITY: state <= TX_STOP;
        default:   state <= TX_IDLE; // End of stop bit.
      endcase
    end
  end

  always_comb
  begin
    case (state)
      TX_START:  tx = 1'b0;
      TX_DATA:   tx = data_q[bit_idx]; // LSB first.
      TX_PARITY: tx = parity;
      default:   tx = 1'b1;
    endcase
  end

  assign byte_if.busy = (state != TX_IDLE);
  assign byte_if.done = (state == TX_STOP) && bit_end;

endmodule

// File: rtl/uart_rx_deserializer.sv
`timescale 1ns/1ps

module uart_rx_deserializer
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  input  logic                  rx_arm,
  output logic                  rx_valid,
  output logic [BYTE_WIDTH-1:0] rx_data,
  output logic                  rx_err
);

  rx_state_t            state;
  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_d;
  logic                 fall;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [2:0]           bit_idx;
  logic                 par_q;
  logic                 half_pt;
  logic                 mid_pt;

  // Two-flop synchronizer plus one stage for edge detection.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign fall    = rx_d & ~rx_s2;
  assign half_pt = (bit_cnt == BIT_CNT_W'(HALF_BIT_CLKS - 1));
  assign mid_pt  = (bit_cnt == BIT_CNT_W'(BIT_CLKS - 1)); // One bit after the last sample.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      bit_cnt  <= bit_cnt + 1'b1;
      case (state)
        RX_IDLE:
        begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (rx_arm && fall)
            state <= RX_START;
        end
        RX_START:
          if (half_pt)
          begin
            bit_cnt <= '0;
            state   <= rx_s2 ? RX_IDLE : RX_DATA; // Glitch, not a start bit.
          end
        RX_DATA:
          if (mid_pt)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= RX_PARITY;
          end
        RX_PARITY:
          if (mid_pt)
            state <= RX_STOP;
        default:
          if (mid_pt)
          begin
            rx_valid <= 1'b1;
            state    <= RX_IDLE;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_DATA && mid_pt)
      rx_data <= {rx_s2, rx_data[BYTE_WIDTH-1:1]}; // LSB arrives first.
    if (state == RX_PARITY && mid_pt)
      par_q <= rx_s2;
    if (state == RX_STOP && mid_pt)
      rx_err <= ~(^{rx_data, par_q}) | ~rx_s2;
  end

endmodule

// File: rtl/uart_cmd_sequencer.sv
`timescale 1ns/1ps

module uart_cmd_sequencer
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  uart_tx_byte_if.seq           byte_if,
  output logic                  rx_arm,
  input  logic                  rx_valid,
  input  logic [BYTE_WIDTH-1:0] rx_data,
  input  logic                  rx_err,
  output logic [BYTE_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  seq_state_t           state;
  logic [CMD_WIDTH-1:0] cmd_buf;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic                 start_q;
  logic                 accept;

  assign cmd_rdy = (state == SEQ_IDLE);
  assign accept  = cmd_vld & cmd_rdy;
  assign rx_arm  = (state == SEQ_WAIT_READ);

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_buf <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      gap_cnt  <= '0;
      start_q  <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      start_q  <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        SEQ_IDLE:
          if (accept)
          begin
            start_q <= 1'b1; // Serializer is idle here.
            state   <= SEQ_SEND_HIGH;
          end
        SEQ_SEND_HIGH:
          if (byte_if.done)
          begin
            gap_cnt <= '0;
            state   <= cmd_buf[WRITE_FLAG_BIT] ? SEQ_GAP : SEQ_WAIT_READ;
          end
        SEQ_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_CNT_W'(GAP_CLKS - 1))
          begin
            start_q <= 1'b1;
            state   <= SEQ_SEND_LOW;
          end
        end
        SEQ_SEND_LOW:
          if (byte_if.done)
            state <= SEQ_IDLE;
        default:
        begin
          // Hold one more cycle so cmd_rdy rises after the strobe.
          if (read_rdy)
            state <= SEQ_IDLE;
          else if (rx_valid)
          begin
            read_rdy <= 1'b1;
            read_err <= rx_err;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == SEQ_WAIT_READ && rx_valid)
      read_data <= rx_data;
  end

  assign byte_if.start = start_q;
  assign byte_if.data  = (state == SEQ_SEND_LOW) ? cmd_buf[BYTE_WIDTH-1:0]
                                                 : cmd_buf[CMD_WIDTH-1 -: BYTE_WIDTH];

endmodule

// File: rtl/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  input  logic                  rx,
  output logic                  cmd_rdy,
  output logic                  tx,
  output logic [BYTE_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  logic                  rx_arm;
  logic                  rx_valid;
  logic [BYTE_WIDTH-1:0] rx_data;
  logic                  rx_err;

  uart_tx_byte_if u_tx_byte_if ();

  uart_rx_deserializer u_rx_deserializer (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_err   (rx_err)
  );

  uart_cmd_sequencer u_cmd_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_if   (u_tx_byte_if.seq),
    .rx_arm    (rx_arm),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_err    (rx_err),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_serializer u_tx_serializer (
    .clk     (clk),
    .rst_n   (rst_n),
    .byte_if (u_tx_byte_if.ser),
    .tx      (tx)
  );

endmodule

// File: bench/uart_cmd_assertions.sv
`timescale 1ns/1ps

module uart_cmd_assertions (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  int error_count = 0; // Read by the testbench at the end of the run.

  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
  else
  begin
    error_count++;
    $error("read_rdy stayed high for two cycles");
  end

  // Line must rest high while the bridge waits for a command.
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
  else
  begin
    error_count++;
    $error("tx low while cmd_rdy is high");
  end

  a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    error_count++;
    $error("cmd_rdy did not fall after an accepted command");
  end

  a_read_busy: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> !cmd_rdy)
  else
  begin
    error_count++;
    $error("read_rdy while cmd_rdy is high");
  end

endmodule

// File: bench/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps

module tb_uart_cmd_bridge
  import uart_cmd_pkg::*;
();

  localparam int NUM_RANDOM = 200;
  localparam int NUM_CMDS   = NUM_RANDOM + 2;
  localparam int FRAME_CLKS = 11 * BIT_CLKS;
  localparam int LIMIT_CLKS = NUM_CMDS * (2 * FRAME_CLKS + GAP_CLKS + 400);

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  rx;
  logic                  cmd_rdy;
  logic                  tx;
  logic [BYTE_WIDTH-1:0] read_data;
  logic                  read_rdy;
  logic                  read_err;

  logic [BYTE_WIDTH-1:0] mem [128]; // Remote register file.
  logic [10:0]           frame_q[$]; // Decoded tx frames, bit 0 is the start bit.
  int                    frame_cycle_q[$];
  logic [6:0]            read_addr_q[$];
  logic [8:0]            exp_read_q[$]; // {err, data} sent by the remote.
  logic [8:0]            got_read_q[$];
  int                    cycle_cnt = 0;
  int                    frame_cnt = 0;
  int                    write_cnt = 0;
  int                    read_cnt = 0;
  int                    err_cnt = 0;
  int                    noise_cnt = 0;

  uart_cmd_bridge u_uart_cmd_bridge (.*);

  bind uart_cmd_bridge uart_cmd_assertions u_assertions (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
      got_read_q.push_back({read_err, read_data});
  end

  always @(posedge clk)
  begin
    if (u_uart_cmd_bridge.u_assertions.error_count != 0)
    begin
      $display("A protocol assertion failed before %0t ns", $time);
      $display("tests failed");
      $fatal(1, "protocol assertion failed");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  // Remote side of the link, tx decoded at mid-bit.
  initial
  begin
    logic [10:0] bits;
    logic [7:0]  value;
    logic [6:0]  write_addr;
    bit          pending_write;
    int          start_cycle;
    pending_write = 1'b0;
    forever
    begin
      @(negedge clk);
      if (rst_n && tx === 1'b0)
      begin
        start_cycle = cycle_cnt;
        repeat (HALF_BIT_CLKS) @(negedge clk);
        bits[0] = tx;
        for (int i = 1; i < 11; i++)
        begin
          repeat (BIT_CLKS) @(negedge clk);
          bits[i] = tx;
        end
        value = bits[8:1];
        frame_q.push_back(bits);
        frame_cycle_q.push_back(start_cycle);
        frame_cnt++;
        if (pending_write)
        begin
          mem[write_addr] = value;
          pending_write   = 1'b0;
        end
        else if (value[7])
        begin
          pending_write = 1'b1;
          write_addr    = value[6:0];
        end
        else
          read_addr_q.push_back(value[6:0]);
      end
    end
  end

  task automatic send_frame(input logic [7:0] value, input bit bad_par, input bit bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (~^value) ^ bad_par, value, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (BIT_CLKS) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  // Read responses, sent once the stop bit of the request has ended.
  initial
  begin
    logic [6:0] addr;
    bit         bad_par;
    bit         bad_stop;
    int         delay;
    forever
    begin
      @(posedge clk);
      if (read_addr_q.size() != 0)
      begin
        addr     = read_addr_q.pop_front();
        delay    = $urandom_range(300);
        bad_par  = ($urandom_range(7) == 0);
        bad_stop = ($urandom_range(15) == 0);
        exp_read_q.push_back({bad_par | bad_stop, mem[addr]});
        repeat (HALF_BIT_CLKS + 1 + delay) @(posedge clk);
        #1;
        send_frame(mem[addr], bad_par, bad_stop);
      end
    end
  end

  task automatic check_frame(input logic [7:0] expected, output int start_cycle);
    logic [10:0] bits;
    bits        = frame_q.pop_front();
    start_cycle = frame_cycle_q.pop_front();
    check_value(bits[0], 1'b0, "start bit");
    check_value(bits[8:1], expected, "frame data");
    check_value(^bits[9:1], 1'b1, "frame parity");
    check_value(bits[10], 1'b1, "stop bit");
  endtask

  task automatic run_command(input logic [CMD_WIDTH-1:0] cmd);
    int         first_cycle;
    int         second_cycle;
    logic [8:0] expected;
    logic [8:0] got;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      #1;
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    while (!cmd_rdy)
    begin
      if ($urandom_range(3) == 0)
      begin
        cmd_vld = 1'b1; // Busy, so this pulse must be dropped.
        cmd_in  = 16'($urandom);
        noise_cnt++;
      end
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
    end
    check_value(frame_q.size(), cmd[WRITE_FLAG_BIT] ? 2 : 1, "frames per command");
    check_frame(cmd[15:8], first_cycle);
    if (cmd[WRITE_FLAG_BIT])
    begin
      check_value(got_read_q.size(), 0, "read strobes on a write");
      check_frame(cmd[7:0], second_cycle);
      check_value(second_cycle - first_cycle >= FRAME_CLKS + GAP_CLKS, 1, "write gap");
      write_cnt++;
    end
    else
    begin
      check_value(got_read_q.size(), 1, "read strobes per read");
      expected = exp_read_q.pop_front();
      got      = got_read_q.pop_front();
      check_value(got[7:0], expected[7:0], "read_data");
      check_value(got[8], expected[8], "read_err");
      err_cnt += expected[8];
      read_cnt++;
    end
  endtask

  initial
  begin
    repeat (LIMIT_CLKS) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CLKS);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    void'($urandom(32'h2cdb_3bc5));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'($urandom);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_value(tx, 1'b1, "tx after reset");
    check_value(read_rdy, 1'b0, "read_rdy after reset");
    check_value(read_err, 1'b0, "read_err after reset");
    run_command({1'b1, 7'h2a, 8'hc3}); // Write, then read the same register back.
    run_command({1'b0, 7'h2a, 8'h00});
    repeat (NUM_RANDOM) run_command(16'($urandom));
    repeat (2 * FRAME_CLKS) @(posedge clk); // A trailing stray frame would land here.
    check_value(frame_cnt, 2 * write_cnt + read_cnt, "total frame count");
    check_value(err_cnt > 0, 1, "error responses seen");
    check_value(noise_cnt > 0, 1, "stray cmd_vld pulses driven");
    if (u_uart_cmd_bridge.u_assertions.error_count == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("tests failed");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

// File: build.f
rtl/uart_cmd_pkg.sv
rtl/uart_tx_byte_if.sv
rtl/uart_tx_serializer.sv
rtl/uart_rx_deserializer.sv
rtl/uart_cmd_sequencer.sv
rtl/uart_cmd_bridge.sv
bench/uart_cmd_assertions.sv
bench/tb_uart_cmd_bridge.sv
